// File: design/bus_pkg.sv
/*
 * Bus package for the memory harness
 * Word, address and byte-enable widths, plus the packed queue entry
 */
`default_nettype none

package bus_pkg;

  localparam int unsigned AddrWidth   = 32;
  localparam int unsigned DataWidth   = 32;
  localparam int unsigned BeWidth     = DataWidth / 8;
  localparam int unsigned OffsetWidth = AddrWidth - 2;
  localparam int unsigned RegionWidth = 2;

  typedef logic [AddrWidth-1:0]   addr_t;
  typedef logic [DataWidth-1:0]   data_t;
  typedef logic [BeWidth-1:0]     be_t;
  typedef logic [OffsetWidth-1:0] offset_t;

  // ----------------------------------------------------------------------
  // Queue entry layout, MSB first
  // region | we | word offset | be | wdata
  // ----------------------------------------------------------------------
  localparam int unsigned EntryWidth = RegionWidth + 1 + OffsetWidth + BeWidth + DataWidth;

  localparam int unsigned WdataLsb  = 0;
  localparam int unsigned BeLsb     = WdataLsb + DataWidth;
  localparam int unsigned OffsetLsb = BeLsb + BeWidth;
  localparam int unsigned WeBit     = OffsetLsb + OffsetWidth;
  localparam int unsigned RegionLsb = WeBit + 1;

  typedef logic [EntryWidth-1:0] entry_t;

endpackage

`default_nettype wire

// File: design/memmap_pkg.sv
/*
 * Memory map of the harness
 * Region codes, boot ROM and DRAM placement, ROM word tag
 */
`default_nettype none

package memmap_pkg;

  typedef enum logic [1:0] {
    REGION_ROM  = 2'd0,
    REGION_DRAM = 2'd1,
    REGION_NONE = 2'd2
  } region_e;

  // ----------------------------------------------------------------------
  // Boot ROM
  // ----------------------------------------------------------------------
  localparam bus_pkg::addr_t RomBase   = 32'h0001_0000;
  localparam int unsigned    RomWords  = 1024;
  localparam bus_pkg::addr_t RomLength = RomWords * 4;

  // Upper half of every ROM word, index goes in the lower half
  localparam logic [15:0] RomTag = 16'hb007;

  // ----------------------------------------------------------------------
  // DRAM
  // ----------------------------------------------------------------------
  localparam bus_pkg::addr_t DramBase = 32'h8000_0000;

  // Size follows the word count chosen at the top level
  function automatic bus_pkg::addr_t dram_length(input int unsigned num_words);
    return bus_pkg::addr_t'(num_words * 4);
  endfunction

endpackage

`default_nettype wire

// File: design/addr_decoder.sv
/*
 * Address decoder
 * Maps each request to ROM, DRAM or unmapped and registers it as a queue entry
 */
`timescale 1ns/10ps
`default_nettype none

module addr_decoder #(
  parameter int unsigned NumWords = 256
) (
  input  wire                    clk_i,
  input  wire                    rst_ni,
  input  wire                    req_valid_i,
  input  wire                    req_we_i,
  input  wire  bus_pkg::addr_t   req_addr_i,
  input  wire  bus_pkg::be_t     req_be_i,
  input  wire  bus_pkg::data_t   req_wdata_i,
  output logic                   req_ready_o,
  output logic                   push_valid_o,
  output bus_pkg::entry_t        push_entry_o,
  input  wire                    push_ready_i
);

  localparam bus_pkg::addr_t DramLength = memmap_pkg::dram_length(NumWords);

  bus_pkg::addr_t      rom_off;
  bus_pkg::addr_t      dram_off;
  memmap_pkg::region_e region;
  bus_pkg::offset_t    offset;
  bus_pkg::entry_t     entry_q;
  logic                valid_q;
  logic                accept;

  // Byte distance from each base, wraps below the base
  assign rom_off  = req_addr_i - memmap_pkg::RomBase;
  assign dram_off = req_addr_i - memmap_pkg::DramBase;

  always_comb begin
    if (rom_off < memmap_pkg::RomLength) begin
      region = memmap_pkg::REGION_ROM;
      offset = rom_off[bus_pkg::AddrWidth-1:2];
    end else if (dram_off < DramLength) begin
      region = memmap_pkg::REGION_DRAM;
      offset = dram_off[bus_pkg::AddrWidth-1:2];
    end else begin
      region = memmap_pkg::REGION_NONE;
      offset = '0;
    end
  end

  // Output slot frees up when the queue takes it
  assign req_ready_o = !valid_q || push_ready_i;
  assign accept      = req_valid_i && req_ready_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else if (accept) begin
      valid_q <= 1'b1;
    end else if (push_ready_i) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      entry_q <= {region, req_we_i, offset, req_be_i, req_wdata_i};
    end
  end

  assign push_valid_o = valid_q;
  assign push_entry_o = entry_q;

endmodule

`default_nettype wire

// File: design/req_queue.sv
/*
 * Request queue
 * In-order circular buffer between the decoder and the memory responder
 */
`timescale 1ns/10ps
`default_nettype none

module req_queue #(
  parameter int unsigned Depth = 4
) (
  input  wire                    clk_i,
  input  wire                    rst_ni,
  input  wire                    push_valid_i,
  input  wire  bus_pkg::entry_t  push_entry_i,
  output logic                   push_ready_o,
  output logic                   pop_valid_o,
  output bus_pkg::entry_t        pop_entry_o,
  input  wire                    pop_ready_i
);

  localparam int unsigned PtrWidth = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CntWidth = $clog2(Depth + 1);

  bus_pkg::entry_t     mem_q [Depth];
  logic [PtrWidth-1:0] wr_ptr_q;
  logic [PtrWidth-1:0] rd_ptr_q;
  logic [CntWidth-1:0] count_q;
  logic                push;
  logic                pop;

  // Depth need not be a power of two
  function automatic logic [PtrWidth-1:0] next_ptr(input logic [PtrWidth-1:0] ptr);
    if (ptr == PtrWidth'(Depth - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign push_ready_o = (count_q != CntWidth'(Depth));
  assign pop_valid_o  = (count_q != '0);
  assign pop_entry_o  = mem_q[rd_ptr_q];

  assign push = push_valid_i && push_ready_o;
  assign pop  = pop_valid_o && pop_ready_i;

  // ----------------------------------------------------------------------
  // Pointers and occupancy
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // Storage
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= push_entry_i;
    end
  end

endmodule

`default_nettype wire

// File: design/mem_responder.sv
/*
 * Memory responder
 * Runs queued requests against the boot ROM and DRAM, one response per request
 */
`timescale 1ns/10ps
`default_nettype none

module mem_responder #(
  parameter int unsigned NumWords = 256
) (
  input  wire                    clk_i,
  input  wire                    rst_ni,
  input  wire                    pop_valid_i,
  input  wire  bus_pkg::entry_t  pop_entry_i,
  output logic                   pop_ready_o,
  output logic                   resp_valid_o,
  output bus_pkg::data_t         resp_rdata_o,
  output logic                   resp_err_o,
  input  wire                    resp_ready_i
);

  localparam int unsigned IdxWidth = (NumWords > 1) ? $clog2(NumWords) : 1;

  memmap_pkg::region_e region;
  logic                we;
  bus_pkg::offset_t    offset;
  bus_pkg::be_t        be;
  bus_pkg::data_t      wdata;
  logic [IdxWidth-1:0] idx;
  bus_pkg::data_t      rom_word;

  bus_pkg::data_t      dram_q [NumWords];
  bus_pkg::data_t      rdata_d;
  logic                err_d;
  logic                dram_we;
  logic                take;
  logic                resp_valid_q;
  bus_pkg::data_t      rdata_q;
  logic                err_q;

  // ----------------------------------------------------------------------
  // Entry fields
  // ----------------------------------------------------------------------
  assign region = memmap_pkg::region_e'(
                    pop_entry_i[bus_pkg::RegionLsb +: bus_pkg::RegionWidth]);
  assign we     = pop_entry_i[bus_pkg::WeBit];
  assign offset = pop_entry_i[bus_pkg::OffsetLsb +: bus_pkg::OffsetWidth];
  assign be     = pop_entry_i[bus_pkg::BeLsb +: bus_pkg::BeWidth];
  assign wdata  = pop_entry_i[bus_pkg::WdataLsb +: bus_pkg::DataWidth];

  assign idx      = offset[IdxWidth-1:0];
  assign rom_word = {memmap_pkg::RomTag, offset[15:0]};

  // Head is taken when the response slot is free or draining
  assign pop_ready_o = !resp_valid_q || resp_ready_i;
  assign take        = pop_valid_i && pop_ready_o;

  always_comb begin
    rdata_d = '0;
    err_d   = 1'b0;
    dram_we = 1'b0;
    case (region)
      memmap_pkg::REGION_ROM: begin
        if (we) begin
          err_d = 1'b1;
        end else begin
          rdata_d = rom_word;
        end
      end
      memmap_pkg::REGION_DRAM: begin
        if (we) begin
          dram_we = take;
        end else begin
          rdata_d = dram_q[idx];
        end
      end
      default: err_d = 1'b1;
    endcase
  end

  // DRAM starts out cleared
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int w = 0; w < NumWords; w++) begin
        dram_q[w] <= '0;
      end
    end else if (dram_we) begin
      for (int b = 0; b < bus_pkg::BeWidth; b++) begin
        if (be[b]) begin
          dram_q[idx][8*b +: 8] <= wdata[8*b +: 8];
        end
      end
    end
  end

  // ----------------------------------------------------------------------
  // Response register
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      resp_valid_q <= 1'b0;
    end else if (take) begin
      resp_valid_q <= 1'b1;
    end else if (resp_ready_i) begin
      resp_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (take) begin
      rdata_q <= rdata_d;
      err_q   <= err_d;
    end
  end

  assign resp_valid_o = resp_valid_q;
  assign resp_rdata_o = rdata_q;
  assign resp_err_o   = err_q;

endmodule

`default_nettype wire

// File: design/debug_req_gate.sv
/*
 * Debug request gate
 * Masks the debug request for a fixed window after reset so boot code runs first
 */
`timescale 1ns/10ps
`default_nettype none

module debug_req_gate #(
  parameter int unsigned DelayCycles = 500
) (
  input  wire  clk_i,
  input  wire  rst_ni,
  input  wire  debug_req_i,
  output logic debug_req_o
);

  localparam int unsigned CntWidth = (DelayCycles > 0) ? $clog2(DelayCycles + 1) : 1;

  logic [CntWidth-1:0] cnt_q;
  logic                open;

  assign open = (cnt_q == '0);

  // Counts down once per edge and parks at zero
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= CntWidth'(DelayCycles);
    end else if (!open) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  assign debug_req_o = open && debug_req_i;

endmodule

`default_nettype wire

// File: design/harness_top.sv
/*
 * Memory harness top level
 * Decoder, request queue and memory responder in a chain, debug gate beside them
 */
`timescale 1ns/10ps
`default_nettype none

module harness_top #(
  parameter int unsigned NumWords         = 256,
  parameter int unsigned QueueDepth       = 4,
  parameter int unsigned DebugDelayCycles = 500
) (
  input  wire                    clk_i,
  input  wire                    rst_ni,
  input  wire                    req_valid_i,
  input  wire                    req_we_i,
  input  wire  bus_pkg::addr_t   req_addr_i,
  input  wire  bus_pkg::be_t     req_be_i,
  input  wire  bus_pkg::data_t   req_wdata_i,
  output logic                   req_ready_o,
  output logic                   resp_valid_o,
  output bus_pkg::data_t         resp_rdata_o,
  output logic                   resp_err_o,
  input  wire                    resp_ready_i,
  input  wire                    debug_req_i,
  output logic                   debug_req_o
);

  logic            push_valid;
  bus_pkg::entry_t push_entry;
  logic            push_ready;
  logic            pop_valid;
  bus_pkg::entry_t pop_entry;
  logic            pop_ready;

  // ----------------------------------------------------------------------
  // Request path
  // ----------------------------------------------------------------------
  addr_decoder #(
    .NumWords     ( NumWords     )
  ) i_addr_decoder (
    .clk_i        ( clk_i        ),
    .rst_ni       ( rst_ni       ),
    .req_valid_i  ( req_valid_i  ),
    .req_we_i     ( req_we_i     ),
    .req_addr_i   ( req_addr_i   ),
    .req_be_i     ( req_be_i     ),
    .req_wdata_i  ( req_wdata_i  ),
    .req_ready_o  ( req_ready_o  ),
    .push_valid_o ( push_valid   ),
    .push_entry_o ( push_entry   ),
    .push_ready_i ( push_ready   )
  );

  req_queue #(
    .Depth        ( QueueDepth   )
  ) i_req_queue (
    .clk_i        ( clk_i        ),
    .rst_ni       ( rst_ni       ),
    .push_valid_i ( push_valid   ),
    .push_entry_i ( push_entry   ),
    .push_ready_o ( push_ready   ),
    .pop_valid_o  ( pop_valid    ),
    .pop_entry_o  ( pop_entry    ),
    .pop_ready_i  ( pop_ready    )
  );

  mem_responder #(
    .NumWords     ( NumWords     )
  ) i_mem_responder (
    .clk_i        ( clk_i        ),
    .rst_ni       ( rst_ni       ),
    .pop_valid_i  ( pop_valid    ),
    .pop_entry_i  ( pop_entry    ),
    .pop_ready_o  ( pop_ready    ),
    .resp_valid_o ( resp_valid_o ),
    .resp_rdata_o ( resp_rdata_o ),
    .resp_err_o   ( resp_err_o   ),
    .resp_ready_i ( resp_ready_i )
  );

  // Debug
  debug_req_gate #(
    .DelayCycles  ( DebugDelayCycles )
  ) i_debug_req_gate (
    .clk_i        ( clk_i            ),
    .rst_ni       ( rst_ni           ),
    .debug_req_i  ( debug_req_i      ),
    .debug_req_o  ( debug_req_o      )
  );

endmodule

`default_nettype wire

// File: verif/tb_checker.sv
/*
 * Response checker for the memory harness
 * Models the memory map and DRAM, compares every response in order
 */
`timescale 1ns/10ps
`default_nettype none

module tb_checker #(
  parameter int unsigned NumWords   = 256,
  parameter int unsigned QueueDepth = 4,
  parameter int unsigned DebugDelay = 40
) (
  input  wire             clk_i,
  input  wire             rst_ni,
  input  wire             req_valid_i,
  input  wire             req_we_i,
  input  wire  bus_pkg::addr_t req_addr_i,
  input  wire  bus_pkg::be_t   req_be_i,
  input  wire  bus_pkg::data_t req_wdata_i,
  input  wire             req_ready_i,
  input  wire             resp_valid_i,
  input  wire  bus_pkg::data_t resp_rdata_i,
  input  wire             resp_err_i,
  input  wire             resp_ready_i,
  input  wire             debug_req_i,
  input  wire             debug_gated_i,
  output int unsigned     error_count_o,
  output int unsigned     resp_count_o
);

  // Decoder register, queue and response register
  localparam int unsigned MaxInFlight = QueueDepth + 2;

  bus_pkg::data_t dram_model [NumWords];
  logic [32:0]    expect_q [$];
  int unsigned    errors = 0;
  int unsigned    responses = 0;
  int unsigned    edges_since_reset;
  int unsigned    reset_edges = 0;
  int unsigned    in_flight;
  logic           held_q;
  bus_pkg::data_t held_rdata;
  logic           held_err;

  assign error_count_o = errors;
  assign resp_count_o  = responses;

  task automatic report_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
    $display("FAIL %0t %s expected %h got %h", $time, name, expected, actual);
    errors++;
  endtask

  task automatic report_event(input string what);
    $display("ERROR %0t %s", $time, what);
    errors++;
  endtask

  // ----------------------------------------------------------------------
  // Reference model, one expected {err, rdata} per request
  // ----------------------------------------------------------------------
  task automatic model_request(input logic we, input bus_pkg::addr_t addr,
                               input bus_pkg::be_t be, input bus_pkg::data_t wdata);
    bus_pkg::addr_t rom_dist;
    bus_pkg::addr_t dram_dist;
    bus_pkg::addr_t idx;
    rom_dist  = addr - memmap_pkg::RomBase;
    dram_dist = addr - memmap_pkg::DramBase;
    if (rom_dist < memmap_pkg::RomWords * 4) begin
      idx = rom_dist >> 2;
      if (we) begin
        expect_q.push_back({1'b1, 32'h0});
      end else begin
        expect_q.push_back({1'b0, memmap_pkg::RomTag, idx[15:0]});
      end
    end else if (dram_dist < NumWords * 4) begin
      idx = dram_dist >> 2;
      if (we) begin
        for (int b = 0; b < 4; b++) begin
          if (be[b]) begin
            dram_model[idx][8*b +: 8] = wdata[8*b +: 8];
          end
        end
        expect_q.push_back({1'b0, 32'h0});
      end else begin
        expect_q.push_back({1'b0, dram_model[idx]});
      end
    end else begin
      expect_q.push_back({1'b1, 32'h0});
    end
  endtask

  task automatic check_response();
    logic [32:0] exp;
    if (expect_q.size() == 0) begin
      report_event("response arrived with no request outstanding");
    end else begin
      exp = expect_q.pop_front();
      if (resp_err_i !== exp[32]) begin
        report_value("resp_err_o", 32'(exp[32]), 32'(resp_err_i));
      end
      if (resp_rdata_i !== exp[31:0]) begin
        report_value("resp_rdata_o", exp[31:0], resp_rdata_i);
      end
    end
    responses++;
  endtask

  // A waiting response keeps valid, data and error
  task automatic check_hold();
    if (held_q) begin
      if (resp_valid_i !== 1'b1) begin
        report_event("resp_valid_o dropped before the response was taken");
      end
      if (resp_rdata_i !== held_rdata) begin
        report_value("resp_rdata_o", held_rdata, resp_rdata_i);
      end
      if (resp_err_i !== held_err) begin
        report_value("resp_err_o", 32'(held_err), 32'(resp_err_i));
      end
    end
    held_q     = (resp_valid_i === 1'b1) && !resp_ready_i;
    held_rdata = resp_rdata_i;
    held_err   = resp_err_i;
  endtask

  task automatic check_debug();
    if (edges_since_reset <= DebugDelay) begin
      if (debug_gated_i !== 1'b0) begin
        report_value("debug_req_o", 32'd0, 32'(debug_gated_i));
      end
    end else if (debug_gated_i !== debug_req_i) begin
      report_value("debug_req_o", 32'(debug_req_i), 32'(debug_gated_i));
    end
  endtask

  always @(posedge clk_i) begin
    if (!rst_ni) begin
      for (int w = 0; w < NumWords; w++) begin
        dram_model[w] = '0;
      end
      expect_q.delete();
      edges_since_reset = 0;
      held_q            = 1'b0;
      reset_edges++;
      // First edge may still see unreset outputs
      if (reset_edges > 1) begin
        if (resp_valid_i !== 1'b0) begin
          report_value("resp_valid_o", 32'd0, 32'(resp_valid_i));
        end
        if (req_ready_i !== 1'b1) begin
          report_value("req_ready_o", 32'd1, 32'(req_ready_i));
        end
        if (debug_gated_i !== 1'b0) begin
          report_value("debug_req_o", 32'd0, 32'(debug_gated_i));
        end
      end
    end else begin
      edges_since_reset++;
      in_flight = expect_q.size();
      check_debug();
      check_hold();
      if (resp_valid_i && resp_ready_i) begin
        check_response();
      end
      if (req_valid_i && req_ready_i) begin
        if (in_flight >= MaxInFlight) begin
          report_event("request accepted while every stage was already full");
        end
        model_request(req_we_i, req_addr_i, req_be_i, req_wdata_i);
      end
    end
  end

endmodule

`default_nettype wire

// File: verif/tb_top.sv
/*
 * Testbench top for the memory harness
 * Clock, reset, LFSR driven initiator and sink, watchdog and closing report
 */
`timescale 1ns/10ps
`default_nettype none

module tb_top;

  localparam int unsigned NumWords      = 256;
  localparam int unsigned QueueDepth    = 4;
  localparam int unsigned DebugDelay    = 40;
  localparam int unsigned NumReqs       = 600;
  localparam int unsigned ResetCycles   = 8;
  localparam int unsigned ClkPeriod     = 10;
  localparam int unsigned TimeoutCycles = NumReqs * 40 + ResetCycles;

  logic           clk_i;
  logic           rst_ni;
  logic           req_valid_i;
  logic           req_we_i;
  bus_pkg::addr_t req_addr_i;
  bus_pkg::be_t   req_be_i;
  bus_pkg::data_t req_wdata_i;
  logic           req_ready_o;
  logic           resp_valid_o;
  bus_pkg::data_t resp_rdata_o;
  logic           resp_err_o;
  logic           resp_ready_i;
  logic           debug_req_i;
  logic           debug_req_o;

  int unsigned    error_count;
  int unsigned    resp_count;
  int unsigned    issued;
  logic           accepted;
  logic [31:0]    lfsr_q;

  harness_top #(
    .DebugDelayCycles ( DebugDelay )
  ) dut0 (
    .clk_i        ( clk_i        ),
    .rst_ni       ( rst_ni       ),
    .req_valid_i  ( req_valid_i  ),
    .req_we_i     ( req_we_i     ),
    .req_addr_i   ( req_addr_i   ),
    .req_be_i     ( req_be_i     ),
    .req_wdata_i  ( req_wdata_i  ),
    .req_ready_o  ( req_ready_o  ),
    .resp_valid_o ( resp_valid_o ),
    .resp_rdata_o ( resp_rdata_o ),
    .resp_err_o   ( resp_err_o   ),
    .resp_ready_i ( resp_ready_i ),
    .debug_req_i  ( debug_req_i  ),
    .debug_req_o  ( debug_req_o  )
  );

  tb_checker #(
    .NumWords   ( NumWords   ),
    .QueueDepth ( QueueDepth ),
    .DebugDelay ( DebugDelay )
  ) monitor0 (
    .clk_i         ( clk_i        ),
    .rst_ni        ( rst_ni       ),
    .req_valid_i   ( req_valid_i  ),
    .req_we_i      ( req_we_i     ),
    .req_addr_i    ( req_addr_i   ),
    .req_be_i      ( req_be_i     ),
    .req_wdata_i   ( req_wdata_i  ),
    .req_ready_i   ( req_ready_o  ),
    .resp_valid_i  ( resp_valid_o ),
    .resp_rdata_i  ( resp_rdata_o ),
    .resp_err_i    ( resp_err_o   ),
    .resp_ready_i  ( resp_ready_i ),
    .debug_req_i   ( debug_req_i  ),
    .debug_gated_i ( debug_req_o  ),
    .error_count_o ( error_count  ),
    .resp_count_o  ( resp_count   )
  );

  initial clk_i = 1'b0;
  always #(ClkPeriod / 2) clk_i = ~clk_i;

  // ----------------------------------------------------------------------
  // Random bits, x^32 + x^22 + x^2 + x + 1
  // ----------------------------------------------------------------------
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic take_bits(input int unsigned n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_step(lfsr_q);
      v      = {v[30:0], lfsr_q[0]};
    end
  endtask

  // Weighted region choice, low address bits left random
  task automatic new_request();
    logic [31:0] kind;
    logic [31:0] bits;
    take_bits(2, kind);
    case (kind[1:0])
      2'd0: begin
        take_bits(12, bits);
        req_addr_i = memmap_pkg::RomBase + bits[11:0];
      end
      2'd1, 2'd2: begin
        take_bits(10, bits);
        req_addr_i = memmap_pkg::DramBase + bits[9:0];
      end
      default: begin
        take_bits(2, kind);
        take_bits(8, bits);
        case (kind[1:0])
          2'd0:    req_addr_i = memmap_pkg::RomBase - 32'd4 + bits[1:0];
          2'd1:    req_addr_i = memmap_pkg::RomBase + memmap_pkg::RomWords * 4 + bits[7:0];
          2'd2:    req_addr_i = memmap_pkg::DramBase + NumWords * 4 + bits[7:0];
          default: begin
            take_bits(28, bits);
            req_addr_i = {4'h4, bits[27:0]};
          end
        endcase
      end
    endcase
    take_bits(1, bits);
    req_we_i = bits[0];
    take_bits(4, bits);
    req_be_i = bits[3:0];
    take_bits(32, bits);
    req_wdata_i = bits;
  endtask

  // A request that waits keeps its fields
  task automatic drive_inputs(input logic taken);
    logic [31:0] bits;
    if (!req_valid_i || taken) begin
      req_valid_i = 1'b0;
      if (issued < NumReqs) begin
        take_bits(2, bits);
        if (bits[1:0] != 2'b00) begin
          req_valid_i = 1'b1;
          new_request();
        end
      end
    end
    take_bits(1, bits);
    resp_ready_i = bits[0];
    take_bits(1, bits);
    debug_req_i = bits[0];
  endtask

  initial begin
    rst_ni       = 1'b0;
    req_valid_i  = 1'b0;
    req_we_i     = 1'b0;
    req_addr_i   = '0;
    req_be_i     = '0;
    req_wdata_i  = '0;
    resp_ready_i = 1'b0;
    debug_req_i  = 1'b0;
    lfsr_q       = 32'h7e28_96cc;
    issued       = 0;
    repeat (ResetCycles) @(posedge clk_i);
    #1 rst_ni = 1'b1;
    do begin
      @(posedge clk_i);
      accepted = req_valid_i && req_ready_o;
      if (accepted) begin
        issued++;
      end
      #1;
      drive_inputs(accepted);
    end while (resp_count < NumReqs);
    repeat (4) @(posedge clk_i);
    #1;
    $display("Requests %0d, responses %0d, errors %0d", issued, resp_count, error_count);
    if (error_count == 0 && issued == NumReqs && resp_count == NumReqs) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(TimeoutCycles * ClkPeriod);
    $display("Timeout: not all responses arrived within %0d cycles", TimeoutCycles);
    $display("Errors found");
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog.f
design/bus_pkg.sv
design/memmap_pkg.sv
design/addr_decoder.sv
design/req_queue.sv
design/mem_responder.sv
design/debug_req_gate.sv
design/harness_top.sv
verif/tb_checker.sv
verif/tb_top.sv

// File: Bender.yml
package:
  name: mem_harness

sources:
  # Packages first, then the blocks, then the top level
  - design/bus_pkg.sv
  - design/memmap_pkg.sv
  - design/addr_decoder.sv
  - design/req_queue.sv
  - design/mem_responder.sv
  - design/debug_req_gate.sv
  - design/harness_top.sv

  - target: simulation
    files:
      - verif/tb_checker.sv
      - verif/tb_top.sv
